// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal -j 0

SOURCES := $(shell cat $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/axi_mem_model.sv
module axi_mem_model import dcache_pkg::*; #(
    parameter logic [31:0] seed    = 32'd1,
    parameter int          depth_w = 16   // words
) (
    input  logic     clk,
    input  logic     rst,
    input  ar_chan_t ar,
    input  logic     arvalid,
    output logic     arready,
    output r_chan_t  r,
    output logic     rvalid,
    input  logic     rready,
    input  aw_chan_t aw,
    input  logic     awvalid,
    output logic     awready,
    input  w_chan_t  w,
    input  logic     wvalid,
    output logic     wready,
    output logic     bvalid,
    input  logic     bready
);

    logic [data_w-1:0] mem [1 << depth_w];
    logic [31:0] rnd;  // source of the ready and valid gaps
    logic rd_busy, wr_busy;
    logic [depth_w-1:0] rd_ptr, wr_ptr;
    logic [len_w-1:0] rd_left;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // same sequence the testbench uses for its reference
    initial begin
        logic [31:0] s;
        s = seed;
        for (int i = 0; i < (1 << depth_w); i++) begin
            s = xorshift(s);
            mem[i] = s;
        end
    end

    assign r.data = mem[rd_ptr];
    assign r.last = (rd_left == '0);

    always @(posedge clk) begin
        if (rst) begin
            rnd     <= seed;
            arready <= 1'b0;
            rvalid  <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            rd_busy <= 1'b0;
            wr_busy <= 1'b0;
        end else begin
            rnd <= xorshift(rnd);

            arready <= !rd_busy && !(arvalid && arready) && rnd[0];
            if (arvalid && arready) begin
                rd_busy <= 1'b1;
                rd_ptr  <= ar.addr[depth_w+1:2];
                rd_left <= ar.len;
            end
            if (rvalid && rready) begin
                rd_ptr  <= rd_ptr + 1'b1;
                rd_left <= rd_left - 1'b1;
                rvalid  <= !r.last && rnd[1];  // random gap between beats
                if (r.last) begin
                    rd_busy <= 1'b0;
                end
            end else if (rd_busy && !rvalid) begin
                rvalid <= rnd[1];
            end

            awready <= !wr_busy && !(awvalid && awready) && rnd[2];
            if (awvalid && awready) begin
                wr_busy <= 1'b1;
                wr_ptr  <= aw.addr[depth_w+1:2];
            end
            wready <= wr_busy && !bvalid && !(wvalid && wready && w.last) && rnd[3];
            if (wvalid && wready) begin
                for (int b = 0; b < strb_w; b++) begin
                    if (w.strb[b]) begin
                        mem[wr_ptr][8*b +: 8] <= w.data[8*b +: 8];
                    end
                end
                wr_ptr <= wr_ptr + 1'b1;
                if (w.last) begin
                    bvalid <= 1'b1;
                end
            end
            if (bvalid && bready) begin
                bvalid  <= 1'b0;
                wr_busy <= 1'b0;
            end
        end
    end

endmodule

// File: dv/tb_dcache.sv
module tb_dcache import dcache_pkg::*; ();

    localparam int index_width  = 6;
    localparam int offset_width = 5;
    localparam int tag_w        = addr_w - index_width - offset_width;
    localparam int words        = 1 << (offset_width - 2);
    localparam int sets         = 1 << index_width;
    localparam int n_ops        = 2000;
    localparam int max_cycles   = (2 * n_ops + 20) * 200;  // reloads can double the count
    localparam logic [31:0] seed = 32'd99542;

    logic clk, rst, req_valid, busy, rsp_valid;
    cpu_req_t req;
    cpu_rsp_t rsp;
    ar_chan_t ar;
    r_chan_t r;
    aw_chan_t aw;
    w_chan_t w;
    logic arvalid, arready, rvalid, rready;
    logic awvalid, awready, wvalid, wready, bvalid, bready;

    logic [7:0] ref_mem [1 << 18];  // byte image of the whole memory
    logic [1:0][tag_w-1:0] m_tag [sets];
    logic [1:0] m_valid [sets];
    logic [1:0] m_dirty [sets];
    logic m_lru [sets];  // way to replace next

    logic [31:0] rng;
    logic [31:0] last_ar_addr, last_aw_addr;
    int value_errs = 0;
    int proto_errs = 0;
    int cycles = 0;
    int ar_count = 0;
    int aw_count = 0;
    int w_beats = 0;
    int w_idx = 0;
    int last_lat;

    dcache_top #(
        .index_width  (index_width),
        .offset_width (offset_width)
    ) dcache_top_inst (.*);

    axi_mem_model #(.seed (seed)) axi_mem_model_inst (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] ref_word(input logic [31:0] addr);
        logic [17:0] a;
        a = {addr[17:2], 2'b00};
        return {ref_mem[a + 3], ref_mem[a + 2], ref_mem[a + 1], ref_mem[a]};
    endfunction

    task automatic compare_word(input string name, input logic [31:0] exp,
                                input logic [31:0] got);
        assert (got === exp) else begin
            value_errs++;
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic confirm(input logic ok, input string what);
        assert (ok) else begin
            proto_errs++;
            $display("error at %0t: %s", $time, what);
        end
    endtask

    task automatic end_of_run();
        $display("errors: %0d wrong values, %0d protocol", value_errs, proto_errs);
        if (value_errs + proto_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    // two-way LRU cache state, write-allocate
    task automatic model_lookup(input logic [31:0] addr, input logic store, output logic hit,
                                output logic evict, output logic [31:0] evict_line);
        logic [tag_w-1:0] tg;
        logic [index_width-1:0] ix;
        logic vic;
        tg = addr[31 -: tag_w];
        ix = addr[offset_width +: index_width];
        hit = 1'b0;
        evict = 1'b0;
        evict_line = '0;
        for (int k = 0; k < 2; k++) begin
            if (m_valid[ix][k] && m_tag[ix][k] == tg) begin
                hit = 1'b1;
                m_lru[ix] = (k == 0);  // other way goes next
                if (store) begin
                    m_dirty[ix][k] = 1'b1;
                end
            end
        end
        if (!hit) begin
            vic = m_lru[ix];
            evict = m_valid[ix][vic] & m_dirty[ix][vic];
            evict_line = {m_tag[ix][vic], ix, {offset_width{1'b0}}};
            m_tag[ix][vic] = tg;
            m_valid[ix][vic] = 1'b1;
            m_dirty[ix][vic] = store;
            m_lru[ix] = ~vic;
        end
    endtask

    task automatic run_access(input logic [31:0] addr, input logic [3:0] wen,
                              input logic [31:0] wdata);
        logic hit, evict;
        logic [31:0] evict_line, exp_word;
        int ar0, aw0, wb0, lat;
        model_lookup(addr, |wen, hit, evict, evict_line);
        exp_word = ref_word(addr);
        for (int b = 0; b < 4; b++) begin
            if (wen[b]) begin
                ref_mem[{addr[17:2], 2'(b)}] = wdata[8*b +: 8];
            end
        end
        while (busy) @(posedge clk);
        ar0 = ar_count;
        aw0 = aw_count;
        wb0 = w_beats;
        req_valid <= 1'b1;
        req       <= {addr, wen, wdata};
        @(posedge clk);
        req_valid <= 1'b0;
        lat = 1;
        while (!rsp_valid) begin
            @(posedge clk);
            lat++;
        end
        last_lat = lat;
        if (wen == 4'h0) begin
            compare_word("rsp.rdata", exp_word, rsp.rdata);
        end
        if (hit) begin
            confirm(lat == 2, "hit response not one cycle after the request");
            confirm(ar_count == ar0 && aw_count == aw0, "bus burst during a hit");
        end else begin
            confirm(ar_count == ar0 + 1, "miss did not issue exactly one read burst");
            compare_word("ar.addr", {addr[31:offset_width], {offset_width{1'b0}}}, last_ar_addr);
            if (evict) begin
                confirm(aw_count == aw0 + 1, "dirty victim was not written back");
                compare_word("aw.addr", evict_line, last_aw_addr);
                confirm(w_beats - wb0 == words, "write burst is not one line long");
            end else begin
                confirm(aw_count == aw0, "write burst for a clean or empty victim");
            end
        end
    endtask

    // bus monitor and run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            confirm(1'b0, "timeout, the cache stopped answering");
            end_of_run();
        end else if (!rst) begin
            if (arvalid && arready) begin
                ar_count++;
                last_ar_addr = ar.addr;
                compare_word("ar.len", words - 1, 32'(ar.len));
            end
            if (awvalid && awready) begin
                aw_count++;
                last_aw_addr = aw.addr;
                w_idx = 0;
                compare_word("aw.len", words - 1, 32'(aw.len));
            end
            if (wvalid && wready) begin
                compare_word("w.data", ref_word(last_aw_addr + 32'(4 * w_idx)), w.data);
                compare_word("w.strb", 32'h0000_000f, 32'(w.strb));  // whole words go out
                compare_word("w.last", 32'(w_idx == words - 1), 32'(w.last));
                w_idx++;
                w_beats++;
            end
        end
    end

    initial begin
        logic [31:0] s, a, d, line_b;
        logic [3:0] be;
        clk = 1'b0;
        rst = 1'b1;
        req_valid = 1'b0;
        req = '0;
        s = seed;
        for (int i = 0; i < (1 << 16); i++) begin
            s = xorshift(s);
            {ref_mem[4*i+3], ref_mem[4*i+2], ref_mem[4*i+1], ref_mem[4*i]} = s;
        end
        rng = s;
        for (int k = 0; k < sets; k++) begin
            m_valid[k] = '0;
            m_dirty[k] = '0;
            m_lru[k] = 1'b0;
        end

        repeat (10) @(posedge clk);
        rst <= 1'b0;
        repeat (4) begin
            @(posedge clk);
            confirm(!busy && !rsp_valid && !arvalid && !awvalid,
                    "cache active after reset with no request");
            confirm(!wvalid && !rready && !bready,
                    "memory channel handshake active after reset with no request");
        end

        // A, dirty B, A again, then C must push out B
        a = {tag_w'(5), index_width'(9), offset_width'(0)};
        line_b = {tag_w'(6), index_width'(9), offset_width'(0)};
        run_access(a, 4'h0, '0);
        run_access(line_b + 32'd4, 4'b0101, 32'hdead_beef);
        run_access(a, 4'h0, '0);
        run_access({tag_w'(7), index_width'(9), offset_width'(8)}, 4'h0, '0);
        compare_word("aw.addr", line_b, last_aw_addr);
        run_access(a, 4'h0, '0);
        confirm(last_lat == 2, "line A was evicted instead of line B");

        // 3 tags on 4 sets keeps the ways under pressure
        for (int n = 0; n < n_ops; n++) begin
            rng = xorshift(rng);
            a = {tag_w'(1 + (rng >> 20) % 3), index_width'(rng[9:8]), rng[14:12], 2'b00};
            be = rng[15] ? rng[19:16] : 4'h0;  // any byte mix
            rng = xorshift(rng);
            d = rng;
            run_access(a, be, d);
            if (be == 4'h0 && rng[3]) begin
                run_access(a, 4'h0, '0);  // reload, must hit
            end
        end
        end_of_run();
    end

endmodule

// File: rtl/dcache_ctrl.sv
module dcache_ctrl import dcache_pkg::*; #(
    parameter int index_width  = 6,
    parameter int offset_width = 5
) (
    input  logic                                                  clk,
    input  logic                                                  rst,
    input  logic                                                  req_valid,
    input  cpu_req_t                                              req,
    output logic                                                  busy,
    output logic                                                  rsp_valid,
    output cpu_rsp_t                                              rsp,
    input  logic [1:0][addr_w-index_width-offset_width:0]         tag_rd,
    output logic [1:0]                                            tag_we,
    output logic [addr_w-index_width-offset_width:0]              tag_wr,
    output logic [index_width-1:0]                                ram_raddr,
    output logic [index_width-1:0]                                ram_waddr,
    input  logic [1:0][(1 << (offset_width-2))-1:0][data_w-1:0]   bank_rd,
    output logic [1:0][(1 << (offset_width-2))-1:0]               bank_we,
    output logic [data_w-1:0]                                     bank_wdata,
    output logic                                                  fill_start,
    output logic [addr_w-offset_width-1:0]                        fill_addr,
    output logic                                                  evict_start,
    output logic [addr_w-offset_width-1:0]                        evict_addr,
    input  logic [offset_width-3:0]                               evict_idx,
    output logic [data_w-1:0]                                     evict_data,
    input  logic                                                  beat_valid,
    input  logic [offset_width-3:0]                               beat_idx,
    input  logic [data_w-1:0]                                     beat_data,
    input  logic                                                  fill_done,
    input  logic                                                  evict_done
);

    localparam int tag_width  = addr_w - index_width - offset_width;
    localparam int word_sel_w = offset_width - 2;
    localparam int sets       = 1 << index_width;

    typedef enum logic [1:0] {
        st_idle,
        st_wb,    // dirty victim going out
        st_fill,  // line coming in
        st_rsp
    } state_t;

    state_t state, state_nxt;
    logic cmp_valid;  // registered request is being compared this cycle
    cpu_req_t req_q;
    logic [data_w-1:0] fill_word_q;

    logic [sets-1:0] lru;  // per set, the way to replace next
    logic [1:0][sets-1:0] valid_q;
    logic [1:0][sets-1:0] dirty_q;

    logic [tag_width-1:0] req_tag;
    logic [index_width-1:0] req_idx;
    logic [word_sel_w-1:0] req_word;
    logic is_store;
    logic [1:0] way_hit;
    logic hit, miss, hit_way, store_hit;
    logic victim, victim_dirty;
    logic [data_w-1:0] hit_word;

    function automatic logic [data_w-1:0] merge_bytes(
        input logic [data_w-1:0] old_word,
        input logic [data_w-1:0] new_word,
        input logic [strb_w-1:0] strb
    );
        logic [data_w-1:0] res;
        res = old_word;
        for (int b = 0; b < strb_w; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return res;
    endfunction

    assign req_tag  = req_q.addr[addr_w-1 -: tag_width];
    assign req_idx  = req_q.addr[offset_width +: index_width];
    assign req_word = req_q.addr[offset_width-1:2];
    assign is_store = |req_q.wen;

    always_comb begin
        for (int way = 0; way < 2; way++) begin
            way_hit[way] = valid_q[way][req_idx] & tag_rd[way][0]
                         & (tag_rd[way][tag_width:1] == req_tag);
        end
    end

    assign hit       = cmp_valid & (|way_hit);
    assign miss      = cmp_valid & ~(|way_hit);
    assign hit_way   = way_hit[1];
    assign store_hit = hit & is_store;
    assign hit_word  = bank_rd[hit_way][req_word];

    assign victim       = lru[req_idx];  // stable until the fill completes
    assign victim_dirty = valid_q[victim][req_idx] & dirty_q[victim][req_idx];

    assign busy = (state == st_wb) | (state == st_fill) | miss;

    // hold the missing set on the read port so the victim line stays visible
    assign ram_raddr = busy ? req_idx : req.addr[offset_width +: index_width];
    assign ram_waddr = req_idx;

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: if (miss) state_nxt = victim_dirty ? st_wb : st_fill;
            st_wb:   if (evict_done) state_nxt = st_fill;
            st_fill: if (fill_done) state_nxt = st_rsp;
            default: state_nxt = st_idle;
        endcase
    end

    assign evict_start = miss & victim_dirty;
    assign fill_start  = (miss & ~victim_dirty) | ((state == st_wb) & evict_done);
    assign fill_addr   = {req_tag, req_idx};
    assign evict_addr  = {tag_rd[victim][tag_width:1], req_idx};
    assign evict_data  = bank_rd[victim][evict_idx];

    // fill beats go into the victim way, store bytes merged at the request word
    always_comb begin
        bank_we    = '0;
        bank_wdata = beat_data;
        if (beat_valid) begin
            bank_we[victim][beat_idx] = 1'b1;
            if (is_store && beat_idx == req_word) begin
                bank_wdata = merge_bytes(beat_data, req_q.wdata, req_q.wen);
            end
        end else if (store_hit) begin
            bank_we[hit_way][req_word] = 1'b1;
            bank_wdata = merge_bytes(hit_word, req_q.wdata, req_q.wen);
        end
    end

    always_comb begin
        tag_we         = '0;
        tag_we[victim] = fill_done;  // tag lands with the last beat
    end
    assign tag_wr = {req_tag, 1'b1};

    assign rsp_valid = hit | (state == st_rsp);
    assign rsp.rdata = (state == st_rsp) ? fill_word_q : hit_word;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_idle;
            cmp_valid <= 1'b0;
            lru       <= '0;
            valid_q   <= '0;
            dirty_q   <= '0;
        end else begin
            state     <= state_nxt;
            cmp_valid <= req_valid;
            if (hit) begin
                lru[req_idx] <= ~hit_way;
                if (is_store) begin
                    dirty_q[hit_way][req_idx] <= 1'b1;
                end
            end else if (fill_done) begin
                lru[req_idx]              <= ~victim;
                valid_q[victim][req_idx] <= 1'b1;
                dirty_q[victim][req_idx] <= is_store;  // load fill is clean
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            req_q <= req;
        end
        if (beat_valid && beat_idx == req_word) begin
            fill_word_q <= beat_data;
        end
    end

    a_no_req_busy: assert property (@(posedge clk) disable iff (rst) busy |-> !req_valid)
        else $error("dcache_ctrl: request strobed while busy");

    a_one_way_hit: assert property (@(posedge clk) disable iff (rst)
        cmp_valid |-> !(&way_hit))
        else $error("dcache_ctrl: both ways hit");

endmodule

// File: rtl/dcache_pkg.sv
package dcache_pkg;

    localparam int addr_w = 32;          // byte address
    localparam int data_w = 32;          // one word
    localparam int strb_w = data_w / 8;  // byte lanes per word
    localparam int len_w  = 8;           // burst length field, beats minus one

    // one CPU access, wen all zero means load
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [strb_w-1:0] wen;
        logic [data_w-1:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [data_w-1:0] rdata;  // undefined on a store ack
    } cpu_rsp_t;

    // read burst request
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [len_w-1:0]  len;
    } ar_chan_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic              last;
    } r_chan_t;

    // write burst request
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [len_w-1:0]  len;
    } aw_chan_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic [strb_w-1:0] strb;
        logic              last;
    } w_chan_t;

endpackage

// File: rtl/dcache_top.sv
module dcache_top import dcache_pkg::*; #(
    parameter int index_width  = 6,
    parameter int offset_width = 5
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     req_valid,
    input  cpu_req_t req,
    output logic     busy,
    output logic     rsp_valid,
    output cpu_rsp_t rsp,
    output ar_chan_t ar,
    output logic     arvalid,
    input  logic     arready,
    input  r_chan_t  r,
    input  logic     rvalid,
    output logic     rready,
    output aw_chan_t aw,
    output logic     awvalid,
    input  logic     awready,
    output w_chan_t  w,
    output logic     wvalid,
    input  logic     wready,
    input  logic     bvalid,
    output logic     bready
);

    localparam int tag_width  = addr_w - index_width - offset_width;
    localparam int word_sel_w = offset_width - 2;
    localparam int words      = 1 << word_sel_w;
    localparam int line_w     = addr_w - offset_width;

    typedef struct packed {
        logic [tag_width-1:0] tag;
        logic                 valid;
    } tag_entry_t;

    tag_entry_t [1:0] tag_rd;
    tag_entry_t tag_wr;
    logic [1:0] tag_we;
    logic [index_width-1:0] ram_raddr, ram_waddr;
    logic [1:0][words-1:0][data_w-1:0] bank_rd;
    logic [1:0][words-1:0] bank_we;
    logic [data_w-1:0] bank_wdata;

    logic fill_start, evict_start, fill_done, evict_done;
    logic [line_w-1:0] fill_addr, evict_addr;
    logic [word_sel_w-1:0] evict_idx, beat_idx;
    logic [data_w-1:0] evict_data, beat_data;
    logic beat_valid;

    dcache_ctrl #(
        .index_width  (index_width),
        .offset_width (offset_width)
    ) dcache_ctrl_inst (.*);

    line_burst_port #(
        .index_width  (index_width),
        .offset_width (offset_width)
    ) line_burst_port_inst (.*);

    for (genvar g = 0; g < 2; g++) begin : g_way
        dual_port_ram #(
            .entry_t     (tag_entry_t),
            .depth_width (index_width)
        ) tag_ram (
            .clk   (clk),
            .we    (tag_we[g]),
            .waddr (ram_waddr),
            .wdata (tag_wr),
            .raddr (ram_raddr),
            .rdata (tag_rd[g])
        );

        // one bank per word so a whole line reads out in one cycle
        for (genvar k = 0; k < words; k++) begin : g_bank
            dual_port_ram #(
                .entry_t     (logic [data_w-1:0]),
                .depth_width (index_width)
            ) data_bank (
                .clk   (clk),
                .we    (bank_we[g][k]),
                .waddr (ram_waddr),
                .wdata (bank_wdata),
                .raddr (ram_raddr),
                .rdata (bank_rd[g][k])
            );
        end
    end

endmodule

// File: rtl/dual_port_ram.sv
module dual_port_ram #(
    parameter type entry_t     = logic [31:0],
    parameter int  depth_width = 6
) (
    input  logic                   clk,
    input  logic                   we,
    input  logic [depth_width-1:0] waddr,
    input  entry_t                 wdata,
    input  logic [depth_width-1:0] raddr,
    output entry_t                 rdata
);

    entry_t mem [1 << depth_width];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];  // same-address write returns the old entry
    end

    // the first edge comes before the controller has seen reset
    a_we_known: assert property (@(posedge clk) 1'b1 |=> !$isunknown(we))
        else $error("dual_port_ram: write enable unknown");

endmodule

// File: rtl/line_burst_port.sv
module line_burst_port import dcache_pkg::*; #(
    parameter int index_width  = 6,
    parameter int offset_width = 5
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           fill_start,
    input  logic [addr_w-offset_width-1:0] fill_addr,
    input  logic                           evict_start,
    input  logic [addr_w-offset_width-1:0] evict_addr,
    output logic [offset_width-3:0]        evict_idx,
    input  logic [data_w-1:0]              evict_data,
    output logic                           beat_valid,
    output logic [offset_width-3:0]        beat_idx,
    output logic [data_w-1:0]              beat_data,
    output logic                           fill_done,
    output logic                           evict_done,
    output ar_chan_t                       ar,
    output logic                           arvalid,
    input  logic                           arready,
    input  r_chan_t                        r,
    input  logic                           rvalid,
    output logic                           rready,
    output aw_chan_t                       aw,
    output logic                           awvalid,
    input  logic                           awready,
    output w_chan_t                        w,
    output logic                           wvalid,
    input  logic                           wready,
    input  logic                           bvalid,
    output logic                           bready
);

    localparam int words = 1 << (offset_width - 2);
    localparam logic [offset_width-3:0] last_beat = '1;

    logic rd_active, ar_done;
    logic [offset_width-3:0] rd_cnt;
    logic [addr_w-offset_width-1:0] fill_line_q;

    logic wr_active, aw_done, w_done;
    logic [offset_width-3:0] wr_cnt;
    logic [addr_w-offset_width-1:0] evict_line_q;

    // read side
    assign arvalid    = rd_active & ~ar_done;
    assign ar.addr    = {fill_line_q, {offset_width{1'b0}}};
    assign ar.len     = len_w'(words - 1);
    assign rready     = rd_active & ar_done;
    assign beat_valid = rvalid & rready;
    assign beat_idx   = rd_cnt;
    assign beat_data  = r.data;
    assign fill_done  = beat_valid & (rd_cnt == last_beat);

    // write side, data only after the address went out
    assign awvalid    = wr_active & ~aw_done;
    assign aw.addr    = {evict_line_q, {offset_width{1'b0}}};
    assign aw.len     = len_w'(words - 1);
    assign wvalid     = wr_active & aw_done & ~w_done;
    assign w.data     = evict_data;
    assign w.strb     = '1;
    assign w.last     = (wr_cnt == last_beat);
    assign evict_idx  = wr_cnt;
    assign bready     = wr_active & w_done;
    assign evict_done = bvalid & bready;  // line is out once b returns

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_active <= 1'b0;
            ar_done   <= 1'b0;
            rd_cnt    <= '0;
            wr_active <= 1'b0;
            aw_done   <= 1'b0;
            w_done    <= 1'b0;
            wr_cnt    <= '0;
        end else begin
            if (fill_start) rd_active <= 1'b1;
            else if (fill_done) rd_active <= 1'b0;
            if (arvalid && arready) ar_done <= 1'b1;
            else if (fill_done) ar_done <= 1'b0;
            if (beat_valid) rd_cnt <= rd_cnt + 1'b1;  // wraps to 0 after the line

            if (evict_start) wr_active <= 1'b1;
            else if (evict_done) wr_active <= 1'b0;
            if (awvalid && awready) aw_done <= 1'b1;
            else if (evict_done) aw_done <= 1'b0;
            if (wvalid && wready && w.last) w_done <= 1'b1;
            else if (evict_done) w_done <= 1'b0;
            if (wvalid && wready) wr_cnt <= wr_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_start) begin
            fill_line_q <= fill_addr;
        end
        if (evict_start) begin
            evict_line_q <= evict_addr;
        end
    end

    a_rlast_count: assert property (@(posedge clk) disable iff (rst)
        (rvalid && rready) |-> (r.last == (rd_cnt == last_beat)))
        else $error("line_burst_port: rlast off the counted final beat");

    a_fill_idle: assert property (@(posedge clk) disable iff (rst) fill_start |-> !rd_active)
        else $error("line_burst_port: fill start during a read burst");

    a_evict_idle: assert property (@(posedge clk) disable iff (rst) evict_start |-> !wr_active)
        else $error("line_burst_port: evict start during a write burst");

    // refill after a writeback targets the set that was just written out
    a_same_set: assert property (@(posedge clk) disable iff (rst)
        (fill_start && evict_done)
            |-> (fill_addr[index_width-1:0] == evict_line_q[index_width-1:0]))
        else $error("line_burst_port: refill set differs from evicted set");

endmodule

// File: src.f
rtl/dcache_pkg.sv
rtl/dual_port_ram.sv
rtl/dcache_ctrl.sv
rtl/line_burst_port.sv
rtl/dcache_top.sv
dv/axi_mem_model.sv
dv/tb_dcache.sv
